//--- hdl/xbar_pkg.sv
package xbar_pkg;

	// lane geometry of the distribution network
	parameter int XBAR_DATA_WIDTH = 16;
	parameter int XBAR_NUM_IN     = 16; // power of two
	parameter int XBAR_NUM_OUT    = 4;

	// inputs per first-stage mux of the crossbar
	parameter int XBAR_MUX_RADIX  = 4;

	localparam int XBAR_SRC_W = $clog2(XBAR_NUM_IN);
	localparam int XBAR_OUT_W = $clog2(XBAR_NUM_OUT);

	// one word carried on a lane
	typedef logic [XBAR_DATA_WIDTH-1:0] lane_word_t;

	// index of an input lane, as written by the host
	typedef logic [XBAR_SRC_W-1:0] src_idx_t;

	// index of an output lane, selects the route entry
	typedef logic [XBAR_OUT_W-1:0] out_idx_t;

	// host port states
	// IDLE waits for req, HOLD keeps ack up until req drops
	typedef enum logic {
		CFG_IDLE,
		CFG_HOLD
	} cfg_state_e;

endpackage

//--- hdl/xbar_route_cfg.sv
module xbar_route_cfg #(
	parameter int NUM_IN  = 16,
	parameter int NUM_OUT = 4
) (
	input  logic                         clk,
	input  logic                         i_rst,

	// host write port, four-phase req/ack
	input  logic                         i_cfg_req,
	input  logic [$clog2(NUM_OUT)-1:0]   i_cfg_out,
	input  logic [$clog2(NUM_IN)-1:0]    i_cfg_src,
	input  logic                         i_cfg_en,
	output logic                         o_cfg_ack,

	// one-hot command toward the crossbar
	output logic [NUM_IN*NUM_OUT-1:0]    o_cmd
);
	import xbar_pkg::*;

	localparam int SRC_W = $clog2(NUM_IN);

	cfg_state_e state_q;
	cfg_state_e state_d;
	logic       wr; // entry written this cycle

	// route table, one entry per output
	logic [NUM_OUT-1:0]            route_en_q;
	logic [NUM_OUT-1:0]            route_en_d;
	logic [NUM_OUT-1:0][SRC_W-1:0] route_src_q;
	logic [NUM_OUT-1:0][SRC_W-1:0] route_src_d;

	logic [NUM_IN*NUM_OUT-1:0]     cmd_d;
	logic [NUM_IN*NUM_OUT-1:0]     cmd_q;

	// handshake FSM
	always_comb
	begin
		state_d = state_q;
		wr      = 1'b0;
		case (state_q)
			CFG_IDLE:
			begin
				if (i_cfg_req)
				begin
					state_d = CFG_HOLD;
					wr      = 1'b1;
				end
			end
			CFG_HOLD:
			begin
				if (!i_cfg_req)
					state_d = CFG_IDLE; // release ack
			end
			default:
			begin
				state_d = CFG_IDLE;
			end
		endcase
	end

	// table contents after this edge
	always_comb
	begin
		route_en_d  = route_en_q;
		route_src_d = route_src_q;
		if (wr)
		begin
			route_en_d[i_cfg_out]  = i_cfg_en;
			route_src_d[i_cfg_out] = i_cfg_src;
		end
	end

	// expand table into one column per output
	// decoding the next table lets a new route take effect one edge after the write
	always_comb
	begin
		cmd_d = '0;
		for (int o = 0; o < NUM_OUT; o++)
		begin
			if (route_en_d[o])
				cmd_d[route_src_d[o]*NUM_OUT + o] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_rst)
		begin
			state_q    <= CFG_IDLE;
			route_en_q <= '0;
			cmd_q      <= '0;
		end
		else
		begin
			state_q    <= state_d;
			route_en_q <= route_en_d;
			cmd_q      <= cmd_d;
		end
	end

	always_ff @(posedge clk)
	begin
		route_src_q <= route_src_d;
	end

	assign o_cfg_ack = (state_q == CFG_HOLD);
	assign o_cmd     = cmd_q;

endmodule

//--- hdl/xbar_one_hot_seq.sv
module xbar_one_hot_seq #(
	parameter int DATA_WIDTH = 16,
	parameter int NUM_IN     = 16, // power of two, multiple of MUX_RADIX
	parameter int NUM_OUT    = 4,
	parameter int MUX_RADIX  = 4
) (
	input  logic                           clk,
	input  logic                           i_rst,
	input  logic                           i_en,

	input  logic [NUM_IN-1:0]              i_valid,
	input  logic [NUM_IN*DATA_WIDTH-1:0]   i_data,
	input  logic [NUM_IN*NUM_OUT-1:0]      i_cmd, // bit src*NUM_OUT+out

	output logic [NUM_OUT-1:0]             o_valid,
	output logic [NUM_OUT*DATA_WIDTH-1:0]  o_data
);

	localparam int NUM_GRP = NUM_IN / MUX_RADIX; // first-stage muxes per output

	// first stage, one word per group per output
	logic [NUM_OUT-1:0][NUM_GRP-1:0][DATA_WIDTH-1:0] s1_data_d;
	logic [NUM_OUT-1:0][NUM_GRP-1:0][DATA_WIDTH-1:0] s1_data_q;
	logic [NUM_OUT-1:0][NUM_GRP-1:0]                 s1_valid_d;
	logic [NUM_OUT-1:0][NUM_GRP-1:0]                 s1_valid_q;

	// second stage, final select per output
	logic [NUM_OUT-1:0][DATA_WIDTH-1:0]              s2_data_d;
	logic [NUM_OUT-1:0][DATA_WIDTH-1:0]              s2_data_q;
	logic [NUM_OUT-1:0]                              s2_valid_d;
	logic [NUM_OUT-1:0]                              s2_valid_q;

	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_out
		logic [DATA_WIDTH-1:0] fin_data;

		for (genvar g = 0; g < NUM_GRP; g++)
		begin : g_grp
			logic [MUX_RADIX-1:0]  sel;
			logic [DATA_WIDTH-1:0] mux_data;

			// command bits of the lanes in this group
			for (genvar k = 0; k < MUX_RADIX; k++)
			begin : g_sel
				assign sel[k] = i_cmd[(g*MUX_RADIX + k)*NUM_OUT + o];
			end

			// sel is at most one-hot, so an OR of the gated lanes is the mux
			always_comb
			begin
				mux_data = '0;
				for (int k = 0; k < MUX_RADIX; k++)
				begin
					if (sel[k] && i_valid[g*MUX_RADIX + k])
						mux_data |= i_data[(g*MUX_RADIX + k)*DATA_WIDTH +: DATA_WIDTH];
				end
			end

			assign s1_data_d[o][g]  = mux_data;
			assign s1_valid_d[o][g] = |sel; // routed, even if lane idle
		end

		// pick the one group that holds the route
		always_comb
		begin
			fin_data = '0;
			for (int g = 0; g < NUM_GRP; g++)
			begin
				if (s1_valid_q[o][g])
					fin_data |= s1_data_q[o][g];
			end
		end

		assign s2_data_d[o]  = fin_data;
		assign s2_valid_d[o] = |s1_valid_q[o];
	end

	// low enable flushes both stages
	always_ff @(posedge clk)
	begin
		if (i_rst || !i_en)
		begin
			s1_data_q  <= '0;
			s1_valid_q <= '0;
			s2_data_q  <= '0;
			s2_valid_q <= '0;
		end
		else
		begin
			s1_data_q  <= s1_data_d;
			s1_valid_q <= s1_valid_d;
			s2_data_q  <= s2_data_d;
			s2_valid_q <= s2_valid_d;
		end
	end

	assign o_valid = s2_valid_q;
	assign o_data  = s2_data_q;

endmodule

//--- hdl/xbar_dist_top.sv
module xbar_dist_top (
	input  logic                                                 clk,
	input  logic                                                 i_rst,

	// data side
	input  logic                                                 i_en,
	input  logic [xbar_pkg::XBAR_NUM_IN-1:0]                     i_valid,
	input  xbar_pkg::lane_word_t [xbar_pkg::XBAR_NUM_IN-1:0]     i_data,

	// host route port
	input  logic                                                 i_cfg_req,
	input  xbar_pkg::out_idx_t                                   i_cfg_out,
	input  xbar_pkg::src_idx_t                                   i_cfg_src,
	input  logic                                                 i_cfg_en,
	output logic                                                 o_cfg_ack,

	output logic [xbar_pkg::XBAR_NUM_OUT-1:0]                    o_valid,
	output xbar_pkg::lane_word_t [xbar_pkg::XBAR_NUM_OUT-1:0]    o_data
);

	logic [xbar_pkg::XBAR_NUM_IN*xbar_pkg::XBAR_NUM_OUT-1:0] cmd; // one-hot per output

	xbar_route_cfg #(
		.NUM_IN  (xbar_pkg::XBAR_NUM_IN),
		.NUM_OUT (xbar_pkg::XBAR_NUM_OUT)
	) cfg0 (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_cfg_req (i_cfg_req),
		.i_cfg_out (i_cfg_out),
		.i_cfg_src (i_cfg_src),
		.i_cfg_en  (i_cfg_en),
		.o_cfg_ack (o_cfg_ack),
		.o_cmd     (cmd)
	);

	xbar_one_hot_seq #(
		.DATA_WIDTH (xbar_pkg::XBAR_DATA_WIDTH),
		.NUM_IN     (xbar_pkg::XBAR_NUM_IN),
		.NUM_OUT    (xbar_pkg::XBAR_NUM_OUT),
		.MUX_RADIX  (xbar_pkg::XBAR_MUX_RADIX)
	) xbar0 (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_en    (i_en),
		.i_valid (i_valid),
		.i_data  (i_data),
		.i_cmd   (cmd),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

endmodule

//--- verif/xbar_dist_props.sv
module xbar_dist_props (
	input logic                               clk,
	input logic                               i_rst,
	input logic                               i_en,
	input logic                               i_cfg_req,
	input logic                               i_cfg_ack,
	input logic [xbar_pkg::XBAR_NUM_OUT-1:0]  i_out_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// ack rises only on an edge that saw req
	ack_rise_on_req: assert property (@(posedge clk) disable iff (i_rst)
		$rose(i_cfg_ack) |-> $past(i_cfg_req))
		else $error("ack rose without a request");

	ack_fall_after_req: assert property (@(posedge clk) disable iff (i_rst)
		$fell(i_cfg_ack) |-> !$past(i_cfg_req))
		else $error("ack fell while the request was still high");

	valid_low_after_rst: assert property (@(posedge clk)
		i_rst |=> (i_out_valid == '0))
		else $error("outputs valid in the cycle after reset");

	// both stages flushed by a low enable
	valid_low_after_en: assert property (@(posedge clk) disable iff (i_rst)
		!i_en |-> ##2 (i_out_valid == '0))
		else $error("outputs valid two cycles after enable low");

endmodule

bind xbar_dist_top xbar_dist_props props0 (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_en        (i_en),
	.i_cfg_req   (i_cfg_req),
	.i_cfg_ack   (o_cfg_ack),
	.i_out_valid (o_valid)
);

//--- verif/tb_xbar_dist.sv
module tb_xbar_dist;
	timeunit 1ns;
	timeprecision 1ps;

	import xbar_pkg::*;

	localparam int NI          = XBAR_NUM_IN;
	localparam int NO          = XBAR_NUM_OUT;
	localparam int DW          = XBAR_DATA_WIDTH;
	localparam int EXP_W       = NO + NO*DW; // valid bits above data words
	localparam int TIMEOUT_CYC = 20;

	logic                clk;
	logic                i_rst;
	logic                i_en;
	logic [NI-1:0]       i_valid;
	lane_word_t [NI-1:0] i_data;
	logic                i_cfg_req;
	out_idx_t            i_cfg_out;
	src_idx_t            i_cfg_src;
	logic                i_cfg_en;
	logic                o_cfg_ack;
	logic [NO-1:0]       o_valid;
	lane_word_t [NO-1:0] o_data;

	// mirror of the route table and of the host port
	logic [NO-1:0]       tbl_en;
	src_idx_t [NO-1:0]   tbl_src;
	logic                hold;
	logic                model_live;

	// [0] sampled at the last edge, [1] due on the outputs now
	logic [NO-1:0]       hist_valid [2];
	lane_word_t [NO-1:0] hist_data [2];
	logic [EXP_W-1:0]    exp_now;

	logic [31:0]         lane_rng;
	logic [31:0]         route_rng;
	int                  value_errors;
	int                  timeouts;

	xbar_dist_top dut0 (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_en      (i_en),
		.i_valid   (i_valid),
		.i_data    (i_data),
		.i_cfg_req (i_cfg_req),
		.i_cfg_out (i_cfg_out),
		.i_cfg_src (i_cfg_src),
		.i_cfg_en  (i_cfg_en),
		.o_cfg_ack (o_cfg_ack),
		.o_valid   (o_valid),
		.o_data    (o_data)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// expected outputs for one input set under a given table
	function automatic logic [EXP_W-1:0] route_lanes(
		input logic [NO-1:0]       en_tbl,
		input src_idx_t [NO-1:0]   src_tbl,
		input logic [NI-1:0]       valid,
		input lane_word_t [NI-1:0] data,
		input logic                en
	);
		logic [NO-1:0]       v;
		lane_word_t [NO-1:0] d;
		v = '0;
		d = '0;
		if (en)
		begin
			for (int o = 0; o < NO; o++)
			begin
				if (en_tbl[o])
				begin
					v[o] = 1'b1; // routed output is valid even for an idle lane
					if (valid[src_tbl[o]])
						d[o] = data[src_tbl[o]];
				end
			end
		end
		return {v, d};
	endfunction

	// reference model, runs on the sampling edge
	always @(posedge clk)
	begin
		hist_valid[1] = (i_rst || !i_en) ? '0 : hist_valid[0];
		hist_data[1]  = (i_rst || !i_en) ? '0 : hist_data[0];
		exp_now       = route_lanes(tbl_en, tbl_src, i_valid, i_data, i_en && !i_rst);
		hist_valid[0] = exp_now[EXP_W-1 -: NO];
		hist_data[0]  = exp_now[NO*DW-1:0];
		// a write on this edge only governs later samples
		if (i_rst)
		begin
			tbl_en     = '0;
			hold       = 1'b0;
			model_live = 1'b1;
		end
		else if (!hold && i_cfg_req)
		begin
			tbl_en[i_cfg_out]  = i_cfg_en;
			tbl_src[i_cfg_out] = i_cfg_src;
			hold               = 1'b1;
		end
		else if (hold && !i_cfg_req)
		begin
			hold = 1'b0;
		end
	end

	// compare where outputs are stable
	always @(negedge clk)
	begin
		if (model_live)
		begin
			for (int o = 0; o < NO; o++)
			begin
				assert (o_valid[o] === hist_valid[1][o])
				else
				begin
					value_errors++;
					$display("** Error at %0d ns: o_valid[%0d] expected %0b actual %0b",
						$time, o, hist_valid[1][o], o_valid[o]);
				end
				assert (o_data[o] === hist_data[1][o])
				else
				begin
					value_errors++;
					$display("** Error at %0d ns: o_data[%0d] expected %h actual %h",
						$time, o, hist_data[1][o], o_data[o]);
				end
			end
			assert (o_cfg_ack === hold)
			else
			begin
				value_errors++;
				$display("** Error at %0d ns: o_cfg_ack expected %0b actual %0b",
					$time, hold, o_cfg_ack);
			end
		end
	end

	// random lane traffic
	always @(negedge clk)
	begin
		lane_rng = xorshift(lane_rng);
		i_valid  = lane_rng[NI-1:0];
		for (int l = 0; l < NI; l++)
		begin
			lane_rng  = xorshift(lane_rng);
			i_data[l] = lane_rng[DW-1:0];
		end
	end

	task automatic run_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// four-phase host write
	task automatic write_route(input out_idx_t out, input src_idx_t src, input logic en);
		int n;
		@(negedge clk);
		i_cfg_out = out;
		i_cfg_src = src;
		i_cfg_en  = en;
		i_cfg_req = 1'b1;
		n = 0;
		while (o_cfg_ack !== 1'b1 && n < TIMEOUT_CYC)
		begin
			@(negedge clk);
			n++;
		end
		if (o_cfg_ack !== 1'b1)
		begin
			timeouts++;
			$display("write to output %0d: ack did not rise within %0d cycles (%0d ns)",
				out, TIMEOUT_CYC, $time);
		end
		i_cfg_req = 1'b0;
		n = 0;
		while (o_cfg_ack !== 1'b0 && n < TIMEOUT_CYC)
		begin
			@(negedge clk);
			n++;
		end
		if (o_cfg_ack !== 1'b0)
		begin
			timeouts++;
			$display("write to output %0d: ack did not fall within %0d cycles (%0d ns)",
				out, TIMEOUT_CYC, $time);
		end
	endtask

	task automatic finish_run;
		$display("errors: %0d mismatches, %0d handshake timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	initial
	begin
		int start;
		int stride;
		src_idx_t pick;
		i_rst         = 1'b1;
		i_en          = 1'b0;
		i_valid       = '0;
		i_data        = '0;
		i_cfg_req     = 1'b0;
		i_cfg_out     = '0;
		i_cfg_src     = '0;
		i_cfg_en      = 1'b0;
		hist_valid[0] = '0;
		hist_valid[1] = '0;
		hist_data[0]  = '0;
		hist_data[1]  = '0;
		model_live    = 1'b0;
		value_errors  = 0;
		timeouts      = 0;
		lane_rng      = 32'd89874;
		route_rng     = 32'd89874;

		repeat (16) @(negedge clk);
		i_rst = 1'b0;
		i_en  = 1'b1;

		// nothing routed yet
		run_cycles(20);

		// distinct sources, odd stride over a power-of-two lane count
		route_rng = xorshift(route_rng);
		start     = route_rng % NI;
		stride    = ((route_rng >> 8) & 32'hE) | 1;
		for (int o = 0; o < NO; o++)
			write_route(o, (start + o*stride) % NI, 1'b1);
		run_cycles(30);

		// multicast
		route_rng = xorshift(route_rng);
		pick      = route_rng % NI;
		for (int o = 0; o < NO; o++)
			write_route(o, pick, 1'b1);
		run_cycles(30);

		// reroute while traffic streams
		for (int i = 0; i < 4; i++)
		begin
			route_rng = xorshift(route_rng);
			write_route(i % NO, route_rng % NI, 1'b1);
			run_cycles(i);
		end
		run_cycles(20);

		// disabled route, then a one-cycle flush
		write_route(NO-1, '0, 1'b0);
		run_cycles(10);
		i_en = 1'b0;
		run_cycles(1);
		i_en = 1'b1;
		run_cycles(20);

		finish_run();
	end

endmodule

//--- list.f
hdl/xbar_pkg.sv
hdl/xbar_route_cfg.sv
hdl/xbar_one_hot_seq.sv
hdl/xbar_dist_top.sv
verif/xbar_dist_props.sv
verif/tb_xbar_dist.sv

//--- Bender.yml
package:
  name: xbar_dist

sources:
  - files:
      - hdl/xbar_pkg.sv
      - hdl/xbar_route_cfg.sv
      - hdl/xbar_one_hot_seq.sv
      - hdl/xbar_dist_top.sv
  - target: test
    files:
      - verif/xbar_dist_props.sv
      - verif/tb_xbar_dist.sv
